/* tb/jtag_debug_testdata.txt */
# name op addr data expected, hex fields; data xxxxxxxx means a random word
# reset op: data 0 is five TMS-high clocks, data 1 is a trst pulse
idcode_after_reset idcode 00 00000000 0a51c0d3
write_cdr          write  00 12345678 12345678
write_prbs_random  write  01 xxxxxxxx xxxxxxxx
write_adc          write  02 0000beef 0000beef
read_cdr           read   00 00000000 12345678
status_phase       status 10 1111a001 1111a001
status_freq        status 11 2222b002 2222b002
status_err         status 12 3333c003 3333c003
status_total       status 13 4444d004 4444d004
stream_even        stream 10 1111a001 3333c003
stream_odd         stream 11 2222b002 4444d004
write_status       write  12 deadbeef 3333c003
write_unmapped     write  40 cafef00d 00000000
read_unmapped      read   7f 00000000 00000000
bypass_pattern     bypass 00 a5c3961e 4b872c3c
release_clear      write  03 00000000 00000000
reset_tms          reset  00 00000000 0a51c0d3
reset_trst         reset  00 00000001 0a51c0d3
read_adc_after     read   02 00000000 0000beef

/* jtag_debug.f */
src/jtag_pkg.sv
src/dbg_reg_pkg.sv
src/jtag_tap_ctrl.sv
src/jtag_dr_chain.sv
src/dbg_reg_bank.sv
src/jtag_debug_top.sv
tb/jtag_debug_assert.sv
tb/jtag_debug_tb.sv

/* tb/jtag_debug_tb.sv */
`timescale 1ns/100ps

module jtag_debug_tb;

	logic        clk;
	logic        rst_n_i;
	logic        tck_i;
	logic        tms_i;
	logic        tdi_i;
	logic        trst_n_i;
	logic        tdo_o;
	logic        tdo_en_o;
	logic [31:0] phase_est_i;
	logic [31:0] freq_est_i;
	logic [31:0] prbs_err_cnt_i;
	logic [31:0] prbs_total_cnt_i;
	logic [31:0] cdr_ctrl_o;
	logic [31:0] prbs_ctrl_o;
	logic [31:0] adc_ctrl_o;
	logic        int_rstb_o;

	// Expected control registers, index is the register address
	logic [31:0] ctrl_model [4];
	integer      seed;
	integer      test_errors;
	integer      total_tests;
	integer      failed_tests;
	string       test_name;

	jtag_debug_top i_dut (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.tck_i            (tck_i),
		.tms_i            (tms_i),
		.tdi_i            (tdi_i),
		.trst_n_i         (trst_n_i),
		.tdo_o            (tdo_o),
		.tdo_en_o         (tdo_en_o),
		.phase_est_i      (phase_est_i),
		.freq_est_i       (freq_est_i),
		.cdr_ctrl_o       (cdr_ctrl_o),
		.prbs_err_cnt_i   (prbs_err_cnt_i),
		.prbs_total_cnt_i (prbs_total_cnt_i),
		.prbs_ctrl_o      (prbs_ctrl_o),
		.adc_ctrl_o       (adc_ctrl_o),
		.int_rstb_o       (int_rstb_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// One TCK period, 8 clk low then 8 clk high, TDO sampled before the rise
	task automatic jtag_clock(input logic t_ms, input logic t_di, output logic t_do);
		tck_i <= 1'b0;
		tms_i <= t_ms;
		tdi_i <= t_di;
		repeat (8) @(posedge clk);
		t_do = tdo_o;
		tck_i <= 1'b1;
		repeat (8) @(posedge clk);
	endtask

	// Five TMS-high clocks, then park in Run-Test/Idle
	task automatic tap_reset();
		logic dummy;
		repeat (5) jtag_clock(1'b1, 1'b0, dummy);
		jtag_clock(1'b0, 1'b0, dummy);
	endtask

	task automatic shift_ir(input logic [3:0] code);
		logic       dummy;
		logic       bit_out;
		logic [3:0] ir_out;
		jtag_clock(1'b1, 1'b0, dummy);
		jtag_clock(1'b1, 1'b0, dummy);
		jtag_clock(1'b0, 1'b0, dummy);
		jtag_clock(1'b0, 1'b0, dummy);
		for (int i = 0; i < 4; i++) begin
			jtag_clock(i == 3, code[i], bit_out);
			ir_out[i] = bit_out;
		end
		jtag_clock(1'b1, 1'b0, dummy);
		jtag_clock(1'b0, 1'b0, dummy);
		// Capture-IR pattern comes out first
		check_value({test_name, " ir capture"}, 32'h0000_0005, {28'h0, ir_out});
	endtask

	task automatic shift_dr(input logic [31:0] din, input int len, output logic [31:0] dout);
		logic dummy;
		logic bit_out;
		dout = '0;
		jtag_clock(1'b1, 1'b0, dummy);
		jtag_clock(1'b0, 1'b0, dummy);
		jtag_clock(1'b0, 1'b0, dummy);
		for (int i = 0; i < len; i++) begin
			jtag_clock(i == len - 1, din[i], bit_out);
			dout[i] = bit_out;
			if (i < len - 1)
				check_value({test_name, " tdo_en"}, 32'h1, {31'h0, tdo_en_o});
		end
		jtag_clock(1'b1, 1'b0, dummy);
		jtag_clock(1'b0, 1'b0, dummy);
		check_value({test_name, " tdo_en"}, 32'h0, {31'h0, tdo_en_o});
	endtask

	// A data scan also writes the next address, so put back its current value
	function automatic logic [31:0] restore_word(input logic [7:0] addr);
		if (addr < 8'h04)
			return ctrl_model[addr[1:0]];
		else
			return 32'h0;
	endfunction

	task automatic read_reg(input logic [7:0] addr, output logic [31:0] value);
		logic [31:0] junk;
		shift_ir(4'h8);
		shift_dr({24'h0, addr}, 8, junk);
		shift_ir(4'h9);
		shift_dr(restore_word(addr + 8'h01), 32, value);
	endtask

	// Capture bumps the address, so the update lands one above the loaded value
	task automatic write_reg(input logic [7:0] addr, input logic [31:0] value);
		logic [31:0] junk;
		shift_ir(4'h8);
		shift_dr({24'h0, addr - 8'h01}, 8, junk);
		shift_ir(4'h9);
		shift_dr(value, 32, junk);
		if (addr < 8'h04)
			ctrl_model[addr[1:0]] = value;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		if (act_v !== exp_v) begin
			$display("Error in %0s: expected %08h, actual %08h", name, exp_v, act_v);
			test_errors++;
		end
	endtask

	// Bounded wait for the control outputs to reach the model
	task automatic wait_controls(input string name);
		int cycles;
		cycles = 0;
		while ((cdr_ctrl_o !== ctrl_model[0] || prbs_ctrl_o !== ctrl_model[1] ||
				adc_ctrl_o !== ctrl_model[2] || int_rstb_o !== ctrl_model[3][0]) &&
				cycles < 64) begin
			@(posedge clk);
			cycles++;
		end
		if (cycles >= 64) begin
			$display("%0s: control outputs did not settle within 64 clocks", name);
			test_errors++;
		end
		check_value(name, ctrl_model[0], cdr_ctrl_o);
		check_value(name, ctrl_model[1], prbs_ctrl_o);
		check_value(name, ctrl_model[2], adc_ctrl_o);
		check_value(name, {31'h0, ctrl_model[3][0]}, {31'h0, int_rstb_o});
	endtask

	task automatic set_status(input logic [7:0] addr, input logic [31:0] value);
		case (addr)
			8'h10: phase_est_i <= value;
			8'h11: freq_est_i <= value;
			8'h12: prbs_err_cnt_i <= value;
			default: prbs_total_cnt_i <= value;
		endcase
		@(posedge clk);
	endtask

	initial begin
		integer      fd;
		string       line;
		reg [8*16-1:0] op;
		logic [7:0]  addr;
		logic [31:0] data;
		logic [31:0] expv;
		logic [31:0] got;
		logic [31:0] first;
		logic        dummy;
		logic        trst_done;

		seed = 32'h2f132442;
		test_errors = 0;
		total_tests = 0;
		failed_tests = 0;
		test_name = "setup";
		rst_n_i = 1'b0;
		tck_i = 1'b0;
		tms_i = 1'b1;
		tdi_i = 1'b0;
		trst_n_i = 1'b1;
		phase_est_i = '0;
		freq_est_i = '0;
		prbs_err_cnt_i = '0;
		prbs_total_cnt_i = '0;
		ctrl_model[0] = 32'h0000_0421;
		ctrl_model[1] = 32'h0000_0000;
		ctrl_model[2] = 32'h0000_1000;
		ctrl_model[3] = 32'h0000_0001;

		repeat (2) @(posedge clk);
		rst_n_i <= 1'b1;
		@(posedge clk);
		tap_reset();

		fd = $fopen("tb/jtag_debug_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test data file");
			failed_tests++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() < 2 || line[0] == "#")
					continue;
				if ($sscanf(line, "%s %s %h %h %h", test_name, op, addr, data, expv) != 5)
					continue;
				test_errors = 0;
				if ($isunknown(data)) begin
					data = $random(seed);
					expv = data;
				end
				if (op == "idcode") begin
					shift_ir(4'h1);
					shift_dr(32'h0, 32, got);
					check_value(test_name, expv, got);
					wait_controls(test_name);
				end else if (op == "write") begin
					write_reg(addr, data);
					wait_controls(test_name);
					read_reg(addr, got);
					check_value(test_name, expv, got);
				end else if (op == "read") begin
					read_reg(addr, got);
					check_value(test_name, expv, got);
				end else if (op == "status") begin
					set_status(addr, data);
					read_reg(addr, got);
					check_value(test_name, expv, got);
				end else if (op == "stream") begin
					// Each data scan reads one address and writes the next
					shift_ir(4'h8);
					shift_dr({24'h0, addr}, 8, got);
					shift_ir(4'h9);
					shift_dr(restore_word(addr + 8'h01), 32, first);
					check_value(test_name, data, first);
					shift_dr(restore_word(addr + 8'h03), 32, got);
					check_value(test_name, expv, got);
				end else if (op == "bypass") begin
					shift_ir(4'hF);
					shift_dr(data, 32, got);
					check_value(test_name, expv, got);
				end else if (op == "reset") begin
					// Leave IDCODE first so the reset has to restore it
					shift_ir(4'hF);
					if (data[0]) begin
						trst_n_i <= 1'b0;
						repeat (8) @(posedge clk);
						trst_n_i <= 1'b1;
						repeat (8) @(posedge clk);
						jtag_clock(1'b0, 1'b0, dummy);
					end else begin
						tap_reset();
					end
					shift_dr(32'h0, 32, got);
					check_value(test_name, expv, got);
					wait_controls(test_name);
				end else begin
					$display("%0s: unknown operation in the test data", test_name);
					test_errors++;
				end
				total_tests++;
				if (test_errors == 0) begin
					$display("%0s passed", test_name);
				end else begin
					$display("%0s had %0d errors", test_name, test_errors);
					failed_tests++;
				end
			end
			$fclose(fd);
		end

		$display("%0d tests run, %0d passed, %0d with errors, %0d assertion failures",
			total_tests, total_tests - failed_tests, failed_tests,
			i_dut.i_tap_ctrl.i_tap_assert.assert_failures);
		if (failed_tests == 0 && total_tests > 0 &&
				i_dut.i_tap_ctrl.i_tap_assert.assert_failures == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* tb/jtag_debug_assert.sv */
`timescale 1ns/100ps

module jtag_tap_assert (
	input logic                 clk,
	input logic                 rst_n_i,
	input logic                 tck_i,
	input jtag_pkg::tap_state_t tap_state_i,
	input logic                 tdo_en_i,
	input logic                 tck_rise_i,
	input logic                 tck_fall_i
);

	int assert_failures = 0;

	// Output enable only while shifting
	assert property (@(posedge clk) disable iff (!rst_n_i)
		tdo_en_i |-> (tap_state_i == jtag_pkg::SHIFT_DR || tap_state_i == jtag_pkg::SHIFT_IR))
	else begin
		$error("tdo_en high outside a shift state");
		assert_failures++;
	end

	assert property (@(posedge clk) $rose(rst_n_i) |=> tap_state_i == jtag_pkg::TEST_LOGIC_RESET)
	else begin
		$error("TAP not in Test-Logic-Reset after reset");
		assert_failures++;
	end

	// Edge pulses trail the pin by 3 clk and never coincide
	assert property (@(posedge clk) disable iff (!rst_n_i)
		tck_rise_i |-> !tck_fall_i && $past(tck_i, 3) && !$past(tck_i, 4))
	else begin
		$error("TCK rise pulse without a matching pin edge");
		assert_failures++;
	end

	assert property (@(posedge clk) disable iff (!rst_n_i)
		tck_fall_i |-> !$past(tck_i, 3) && $past(tck_i, 4))
	else begin
		$error("TCK fall pulse without a matching pin edge");
		assert_failures++;
	end

endmodule

bind jtag_tap_ctrl jtag_tap_assert i_tap_assert (
	.clk         (clk),
	.rst_n_i     (rst_n_i),
	.tck_i       (tck_i),
	.tap_state_i (tap_state_o),
	.tdo_en_i    (tdo_en_o),
	.tck_rise_i  (tck_rise_o),
	.tck_fall_i  (tck_fall_o)
);

/* src/jtag_debug_top.sv */
`timescale 1ns/100ps
`default_nettype none

module jtag_debug_top (
	input  wire logic                   clk,
	input  wire logic                   rst_n_i,
	// JTAG pins
	input  wire logic                   tck_i,
	input  wire logic                   tms_i,
	input  wire logic                   tdi_i,
	input  wire logic                   trst_n_i,
	output logic                        tdo_o,
	output logic                        tdo_en_o,
	// CDR
	input  wire dbg_reg_pkg::reg_data_t phase_est_i,
	input  wire dbg_reg_pkg::reg_data_t freq_est_i,
	output dbg_reg_pkg::reg_data_t      cdr_ctrl_o,
	// PRBS checker
	input  wire dbg_reg_pkg::reg_data_t prbs_err_cnt_i,
	input  wire dbg_reg_pkg::reg_data_t prbs_total_cnt_i,
	output dbg_reg_pkg::reg_data_t      prbs_ctrl_o,
	// ADC and resets
	output dbg_reg_pkg::reg_data_t      adc_ctrl_o,
	output logic                        int_rstb_o
);

	jtag_pkg::tap_state_t   tap_state;
	jtag_pkg::ir_t          ir;
	logic                   tck_rise;
	logic                   tck_fall;
	logic                   tdo_ir;
	dbg_reg_pkg::reg_addr_t reg_addr;
	dbg_reg_pkg::reg_data_t wr_data;
	dbg_reg_pkg::reg_data_t rd_data;
	logic                   wr_stb;
	logic                   rd_stb;

	jtag_tap_ctrl i_tap_ctrl (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.tck_i       (tck_i),
		.tms_i       (tms_i),
		.tdi_i       (tdi_i),
		.trst_n_i    (trst_n_i),
		.tap_state_o (tap_state),
		.ir_o        (ir),
		.tck_rise_o  (tck_rise),
		.tck_fall_o  (tck_fall),
		.tdo_ir_o    (tdo_ir),
		.tdo_en_o    (tdo_en_o)
	);

	jtag_dr_chain i_dr_chain (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.tap_state_i (tap_state),
		.ir_i        (ir),
		.tck_rise_i  (tck_rise),
		.tck_fall_i  (tck_fall),
		.tdi_i       (tdi_i),
		.tdo_ir_i    (tdo_ir),
		.rd_data_i   (rd_data),
		.reg_addr_o  (reg_addr),
		.wr_data_o   (wr_data),
		.wr_stb_o    (wr_stb),
		.rd_stb_o    (rd_stb),
		.tdo_o       (tdo_o)
	);

	dbg_reg_bank i_reg_bank (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.reg_addr_i       (reg_addr),
		.wr_data_i        (wr_data),
		.wr_stb_i         (wr_stb),
		.rd_stb_i         (rd_stb),
		.phase_est_i      (phase_est_i),
		.freq_est_i       (freq_est_i),
		.prbs_err_cnt_i   (prbs_err_cnt_i),
		.prbs_total_cnt_i (prbs_total_cnt_i),
		.rd_data_o        (rd_data),
		.cdr_ctrl_o       (cdr_ctrl_o),
		.prbs_ctrl_o      (prbs_ctrl_o),
		.adc_ctrl_o       (adc_ctrl_o),
		.int_rstb_o       (int_rstb_o)
	);

endmodule

`default_nettype wire

/* src/dbg_reg_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module dbg_reg_bank (
	input  wire logic                   clk,
	input  wire logic                   rst_n_i,
	input  wire dbg_reg_pkg::reg_addr_t reg_addr_i,
	input  wire dbg_reg_pkg::reg_data_t wr_data_i,
	input  wire logic                   wr_stb_i,
	input  wire logic                   rd_stb_i,
	// CDR status
	input  wire dbg_reg_pkg::reg_data_t phase_est_i,
	input  wire dbg_reg_pkg::reg_data_t freq_est_i,
	// PRBS checker status
	input  wire dbg_reg_pkg::reg_data_t prbs_err_cnt_i,
	input  wire dbg_reg_pkg::reg_data_t prbs_total_cnt_i,
	output dbg_reg_pkg::reg_data_t      rd_data_o,
	output dbg_reg_pkg::reg_data_t      cdr_ctrl_o,
	output dbg_reg_pkg::reg_data_t      prbs_ctrl_o,
	output dbg_reg_pkg::reg_data_t      adc_ctrl_o,
	output logic                        int_rstb_o
);

	dbg_reg_pkg::reg_data_t rst_ctrl;
	dbg_reg_pkg::reg_data_t rd_mux;

	// Control registers, status and unmapped writes dropped
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cdr_ctrl_o  <= dbg_reg_pkg::RST_CDR_CTRL;
			prbs_ctrl_o <= dbg_reg_pkg::RST_PRBS_CTRL;
			adc_ctrl_o  <= dbg_reg_pkg::RST_ADC_CTRL;
			rst_ctrl    <= dbg_reg_pkg::RST_RST_CTRL;
		end else if (wr_stb_i) begin
			case (reg_addr_i)
				dbg_reg_pkg::ADDR_CDR_CTRL:  cdr_ctrl_o  <= wr_data_i;
				dbg_reg_pkg::ADDR_PRBS_CTRL: prbs_ctrl_o <= wr_data_i;
				dbg_reg_pkg::ADDR_ADC_CTRL:  adc_ctrl_o  <= wr_data_i;
				dbg_reg_pkg::ADDR_RST_CTRL:  rst_ctrl    <= wr_data_i;
				default: ;
			endcase
		end
	end

	always_comb begin
		case (reg_addr_i)
			dbg_reg_pkg::ADDR_CDR_CTRL:   rd_mux = cdr_ctrl_o;
			dbg_reg_pkg::ADDR_PRBS_CTRL:  rd_mux = prbs_ctrl_o;
			dbg_reg_pkg::ADDR_ADC_CTRL:   rd_mux = adc_ctrl_o;
			dbg_reg_pkg::ADDR_RST_CTRL:   rd_mux = rst_ctrl;
			dbg_reg_pkg::ADDR_PHASE_EST:  rd_mux = phase_est_i;
			dbg_reg_pkg::ADDR_FREQ_EST:   rd_mux = freq_est_i;
			dbg_reg_pkg::ADDR_PRBS_ERR:   rd_mux = prbs_err_cnt_i;
			dbg_reg_pkg::ADDR_PRBS_TOTAL: rd_mux = prbs_total_cnt_i;
			default:                      rd_mux = '0;
		endcase
	end

	// Snapshot taken on the read strobe, held until the next one
	always_ff @(posedge clk) begin
		if (rd_stb_i)
			rd_data_o <= rd_mux;
	end

	// Receiver blocks stay in reset until software releases them
	assign int_rstb_o = rst_n_i & rst_ctrl[dbg_reg_pkg::RST_RELEASE_BIT];

endmodule

`default_nettype wire

/* src/jtag_dr_chain.sv */
`timescale 1ns/100ps
`default_nettype none

module jtag_dr_chain (
	input  wire logic                   clk,
	input  wire logic                   rst_n_i,
	input  wire jtag_pkg::tap_state_t   tap_state_i,
	input  wire jtag_pkg::ir_t          ir_i,
	input  wire logic                   tck_rise_i,
	input  wire logic                   tck_fall_i,
	input  wire logic                   tdi_i,
	input  wire logic                   tdo_ir_i,
	input  wire dbg_reg_pkg::reg_data_t rd_data_i,
	output dbg_reg_pkg::reg_addr_t      reg_addr_o,
	output dbg_reg_pkg::reg_data_t      wr_data_o,
	output logic                        wr_stb_o,
	output logic                        rd_stb_o,
	output logic                        tdo_o
);

	logic                   tck_rise_d;
	logic                   rd_stb_d;
	logic                   cap_entry;
	logic                   upd_entry;
	logic                   sel_idcode;
	logic                   sel_addr;
	logic                   sel_data;
	dbg_reg_pkg::reg_data_t dr_shift;

	// The state has just advanced one clk after tck_rise
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			tck_rise_d <= 1'b0;
			rd_stb_d   <= 1'b0;
		end else begin
			tck_rise_d <= tck_rise_i;
			rd_stb_d   <= rd_stb_o;
		end
	end

	assign cap_entry = tck_rise_d && (tap_state_i == jtag_pkg::CAPTURE_DR);
	assign upd_entry = tck_rise_d && (tap_state_i == jtag_pkg::UPDATE_DR);

	assign sel_idcode = (ir_i == jtag_pkg::IR_IDCODE);
	assign sel_addr   = (ir_i == jtag_pkg::IR_REG_ADDR);
	assign sel_data   = (ir_i == jtag_pkg::IR_REG_DATA);

	assign rd_stb_o = cap_entry && sel_data;
	assign wr_stb_o = upd_entry && sel_data;

	// One shift register, chain length set by the instruction
	always_ff @(posedge clk) begin
		if (tck_rise_i && (tap_state_i == jtag_pkg::SHIFT_DR)) begin
			if (sel_idcode || sel_data)
				dr_shift <= {tdi_i, dr_shift[dbg_reg_pkg::DATA_WIDTH-1:1]};
			else if (sel_addr)
				dr_shift[dbg_reg_pkg::ADDR_WIDTH-1:0] <=
					{tdi_i, dr_shift[dbg_reg_pkg::ADDR_WIDTH-1:1]};
			else
				dr_shift[0] <= tdi_i;
		end else if (cap_entry) begin
			if (sel_idcode)
				dr_shift <= jtag_pkg::IDCODE_VALUE;
			else if (sel_addr)
				dr_shift <= {{(dbg_reg_pkg::DATA_WIDTH-dbg_reg_pkg::ADDR_WIDTH){1'b0}},
					reg_addr_o};
			else if (!sel_data)
				dr_shift[0] <= 1'b0;
		end else if (rd_stb_d) begin
			// Bank output settles one clk after rd_stb
			dr_shift <= rd_data_i;
		end
	end

	assign wr_data_o = dr_shift;

	// Address register, steps after each data access
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i)
			reg_addr_o <= '0;
		else if (upd_entry && sel_addr)
			reg_addr_o <= dr_shift[dbg_reg_pkg::ADDR_WIDTH-1:0];
		else if (wr_stb_o || rd_stb_o)
			reg_addr_o <= reg_addr_o + dbg_reg_pkg::reg_addr_t'(1);
	end

	// TDO launched on falling TCK
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i)
			tdo_o <= 1'b0;
		else if (tck_fall_i) begin
			if (tap_state_i == jtag_pkg::SHIFT_IR)
				tdo_o <= tdo_ir_i;
			else if (tap_state_i == jtag_pkg::SHIFT_DR)
				tdo_o <= dr_shift[0];
			else
				tdo_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* src/jtag_tap_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module jtag_tap_ctrl (
	input  wire logic            clk,
	input  wire logic            rst_n_i,
	input  wire logic            tck_i,
	input  wire logic            tms_i,
	input  wire logic            tdi_i,
	input  wire logic            trst_n_i,
	output jtag_pkg::tap_state_t tap_state_o,
	output jtag_pkg::ir_t        ir_o,
	output logic                 tck_rise_o,
	output logic                 tck_fall_o,
	output logic                 tdo_ir_o,
	output logic                 tdo_en_o
);

	logic [1:0]           tck_sync;
	logic [1:0]           tms_sync;
	logic [1:0]           trst_sync;
	logic                 tck_prev;
	logic                 tms_s;
	logic                 trst_n_s;
	jtag_pkg::tap_state_t state_next;
	jtag_pkg::ir_t        ir_shift;

	function automatic logic is_shift(input jtag_pkg::tap_state_t s);
		return (s == jtag_pkg::SHIFT_DR) || (s == jtag_pkg::SHIFT_IR);
	endfunction

	// Two-flop synchronizers on the raw pins
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			tck_sync  <= '0;
			tms_sync  <= '1;
			trst_sync <= '0;
		end else begin
			tck_sync  <= {tck_sync[0], tck_i};
			tms_sync  <= {tms_sync[0], tms_i};
			trst_sync <= {trst_sync[0], trst_n_i};
		end
	end

	assign tms_s    = tms_sync[1];
	assign trst_n_s = trst_sync[1];

	// Registered TCK edge pulses
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			tck_prev   <= 1'b0;
			tck_rise_o <= 1'b0;
			tck_fall_o <= 1'b0;
		end else begin
			tck_prev   <= tck_sync[1];
			tck_rise_o <= tck_sync[1] & ~tck_prev;
			tck_fall_o <= ~tck_sync[1] & tck_prev;
		end
	end

	always_comb begin
		unique case (tap_state_o)
			jtag_pkg::TEST_LOGIC_RESET: state_next = tms_s ? jtag_pkg::TEST_LOGIC_RESET : jtag_pkg::RUN_TEST_IDLE;
			jtag_pkg::RUN_TEST_IDLE:    state_next = tms_s ? jtag_pkg::SELECT_DR_SCAN : jtag_pkg::RUN_TEST_IDLE;
			jtag_pkg::SELECT_DR_SCAN:   state_next = tms_s ? jtag_pkg::SELECT_IR_SCAN : jtag_pkg::CAPTURE_DR;
			jtag_pkg::CAPTURE_DR:       state_next = tms_s ? jtag_pkg::EXIT1_DR : jtag_pkg::SHIFT_DR;
			jtag_pkg::SHIFT_DR:         state_next = tms_s ? jtag_pkg::EXIT1_DR : jtag_pkg::SHIFT_DR;
			jtag_pkg::EXIT1_DR:         state_next = tms_s ? jtag_pkg::UPDATE_DR : jtag_pkg::PAUSE_DR;
			jtag_pkg::PAUSE_DR:         state_next = tms_s ? jtag_pkg::EXIT2_DR : jtag_pkg::PAUSE_DR;
			jtag_pkg::EXIT2_DR:         state_next = tms_s ? jtag_pkg::UPDATE_DR : jtag_pkg::SHIFT_DR;
			jtag_pkg::UPDATE_DR:        state_next = tms_s ? jtag_pkg::SELECT_DR_SCAN : jtag_pkg::RUN_TEST_IDLE;
			jtag_pkg::SELECT_IR_SCAN:   state_next = tms_s ? jtag_pkg::TEST_LOGIC_RESET : jtag_pkg::CAPTURE_IR;
			jtag_pkg::CAPTURE_IR:       state_next = tms_s ? jtag_pkg::EXIT1_IR : jtag_pkg::SHIFT_IR;
			jtag_pkg::SHIFT_IR:         state_next = tms_s ? jtag_pkg::EXIT1_IR : jtag_pkg::SHIFT_IR;
			jtag_pkg::EXIT1_IR:         state_next = tms_s ? jtag_pkg::UPDATE_IR : jtag_pkg::PAUSE_IR;
			jtag_pkg::PAUSE_IR:         state_next = tms_s ? jtag_pkg::EXIT2_IR : jtag_pkg::PAUSE_IR;
			jtag_pkg::EXIT2_IR:         state_next = tms_s ? jtag_pkg::UPDATE_IR : jtag_pkg::SHIFT_IR;
			default:                    state_next = tms_s ? jtag_pkg::SELECT_DR_SCAN : jtag_pkg::RUN_TEST_IDLE;
		endcase
	end

	// TAP state and active instruction
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			tap_state_o <= jtag_pkg::TEST_LOGIC_RESET;
			ir_o        <= jtag_pkg::IR_IDCODE;
		end else if (!trst_n_s) begin
			tap_state_o <= jtag_pkg::TEST_LOGIC_RESET;
			ir_o        <= jtag_pkg::IR_IDCODE;
		end else if (tck_rise_o) begin
			tap_state_o <= state_next;
			if (state_next == jtag_pkg::UPDATE_IR)
				ir_o <= ir_shift;
			else if (state_next == jtag_pkg::TEST_LOGIC_RESET)
				ir_o <= jtag_pkg::IR_IDCODE;
		end
	end

	// IR shift stage, LSB out first
	always_ff @(posedge clk) begin
		if (tck_rise_o) begin
			if (tap_state_o == jtag_pkg::SHIFT_IR)
				ir_shift <= {tdi_i, ir_shift[jtag_pkg::IR_WIDTH-1:1]};
			else if (state_next == jtag_pkg::CAPTURE_IR)
				ir_shift <= jtag_pkg::IR_CAPTURE;
		end
	end

	assign tdo_ir_o = ir_shift[0];

	// Set on falling TCK, dropped together with the state leaving shift
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i)
			tdo_en_o <= 1'b0;
		else if (!trst_n_s)
			tdo_en_o <= 1'b0;
		else if (tck_rise_o && !is_shift(state_next))
			tdo_en_o <= 1'b0;
		else if (tck_fall_o)
			tdo_en_o <= is_shift(tap_state_o);
	end

endmodule

`default_nettype wire

/* src/dbg_reg_pkg.sv */
package dbg_reg_pkg;

	localparam int ADDR_WIDTH = 8;
	localparam int DATA_WIDTH = 32;

	typedef logic [ADDR_WIDTH-1:0] reg_addr_t;
	typedef logic [DATA_WIDTH-1:0] reg_data_t;

	// Control registers
	localparam reg_addr_t ADDR_CDR_CTRL  = 8'h00;
	localparam reg_addr_t ADDR_PRBS_CTRL = 8'h01;
	localparam reg_addr_t ADDR_ADC_CTRL  = 8'h02;
	localparam reg_addr_t ADDR_RST_CTRL  = 8'h03;

	// Status words from the receiver blocks
	localparam reg_addr_t ADDR_PHASE_EST  = 8'h10;
	localparam reg_addr_t ADDR_FREQ_EST   = 8'h11;
	localparam reg_addr_t ADDR_PRBS_ERR   = 8'h12;
	localparam reg_addr_t ADDR_PRBS_TOTAL = 8'h13;

	// Control reset values
	localparam reg_data_t RST_CDR_CTRL  = 32'h0000_0421;
	localparam reg_data_t RST_PRBS_CTRL = 32'h0000_0000;
	localparam reg_data_t RST_ADC_CTRL  = 32'h0000_1000;
	localparam reg_data_t RST_RST_CTRL  = 32'h0000_0001;

	// Internal reset release in the reset control word
	localparam int RST_RELEASE_BIT = 0;

endpackage

/* src/jtag_pkg.sv */
package jtag_pkg;

	localparam int IR_WIDTH     = 4;
	localparam int IDCODE_WIDTH = 32;

	typedef logic [IR_WIDTH-1:0]     ir_t;
	typedef logic [IDCODE_WIDTH-1:0] idcode_t;

	// IEEE 1149.1 TAP controller states
	typedef enum logic [3:0] {
		TEST_LOGIC_RESET = 4'h0,
		RUN_TEST_IDLE    = 4'h1,
		SELECT_DR_SCAN   = 4'h2,
		CAPTURE_DR       = 4'h3,
		SHIFT_DR         = 4'h4,
		EXIT1_DR         = 4'h5,
		PAUSE_DR         = 4'h6,
		EXIT2_DR         = 4'h7,
		UPDATE_DR        = 4'h8,
		SELECT_IR_SCAN   = 4'h9,
		CAPTURE_IR       = 4'hA,
		SHIFT_IR         = 4'hB,
		EXIT1_IR         = 4'hC,
		PAUSE_IR         = 4'hD,
		EXIT2_IR         = 4'hE,
		UPDATE_IR        = 4'hF
	} tap_state_t;

	// Instructions, anything else acts as bypass
	localparam ir_t IR_IDCODE   = 4'h1;
	localparam ir_t IR_REG_ADDR = 4'h8;
	localparam ir_t IR_REG_DATA = 4'h9;
	localparam ir_t IR_BYPASS   = 4'hF;

	// Fixed pattern seen on TDO during an IR scan
	localparam ir_t IR_CAPTURE = 4'b0101;

	localparam idcode_t IDCODE_VALUE = 32'h0A51_C0D3;

endpackage
